//--- include/apb_dma_settings.svh
`ifndef APB_DMA_SETTINGS_SVH
`define APB_DMA_SETTINGS_SVH

// bus and memory widths
`define DMA_ADDR_W      32
`define DMA_DATA_W      32
`define DMA_MEM_AW      16
`define DMA_BANK_BIT    20      // 1 selects mem0, 0 selects mem1
`define DMA_SIZE_W      6
`define DMA_FIFO_DEPTH  32

// register map
`define DMA_REG_SRC     32'h0000_0000
`define DMA_REG_DST     32'h0000_0004
`define DMA_REG_SIZE    32'h0000_0008
`define DMA_REG_CTRL    32'h0000_000C
`define DMA_REG_INT     32'h0000_0010

`endif

//--- design/apb_dma_pkg.sv
`include "apb_dma_settings.svh"

package apb_dma_pkg;

    typedef logic [`DMA_ADDR_W-1:0]   addr_t;
    typedef logic [`DMA_DATA_W-1:0]   word_t;
    typedef logic [`DMA_MEM_AW-1:0]   mem_addr_t;
    typedef logic [`DMA_DATA_W/8-1:0] byte_en_t;
    typedef logic [`DMA_SIZE_W-1:0]   size_t;
    typedef logic [`DMA_SIZE_W-2:0]   wcount_t;   // up to 17 words per transfer

    typedef struct packed {
        addr_t src;
        addr_t dst;
        size_t size;
    } dma_cfg_t;

    typedef struct packed {
        logic      en;
        byte_en_t  we;
        mem_addr_t addr;
        word_t     wdata;
    } mem_req_t;

    // tags a read word as it reaches the aligner
    typedef struct packed {
        logic valid;
        logic first;
        logic last;
    } rd_beat_t;

    typedef struct packed {
        logic  push;
        word_t data;
    } fifo_wr_t;

    typedef enum logic [2:0] {IDLE, READ, FLUSH, WRITE, DONE} ctrl_state_t;

endpackage

//--- design/dma_apb_regs.sv
`timescale 1ns/100ps
`include "apb_dma_settings.svh"

module dma_apb_regs (
    input  logic                  CLK,
    input  logic                  RSTN,
    input  logic                  PSEL,
    input  logic                  PENABLE,
    input  logic                  PWRITE,
    input  apb_dma_pkg::addr_t    PADDR,
    input  apb_dma_pkg::word_t    PWDATA,
    output logic                  PREADY,
    output apb_dma_pkg::word_t    PRDATA,
    output logic                  INTR,
    input  logic                  done,
    output logic                  start,
    output apb_dma_pkg::dma_cfg_t cfg
);

    logic               acc;
    logic               busy;
    logic               int_stat;
    apb_dma_pkg::word_t rd_val;

    assign acc  = PSEL & PENABLE & ~PREADY;   // one sample per access
    assign INTR = int_stat;

    always_comb begin
        case (PADDR)
            `DMA_REG_SRC:  rd_val = cfg.src;
            `DMA_REG_DST:  rd_val = cfg.dst;
            `DMA_REG_SIZE: rd_val = apb_dma_pkg::word_t'(cfg.size);
            `DMA_REG_CTRL: rd_val = apb_dma_pkg::word_t'(busy);
            `DMA_REG_INT:  rd_val = apb_dma_pkg::word_t'(int_stat);
            default:       rd_val = '0;
        endcase
    end

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            PREADY   <= 1'b0;
            start    <= 1'b0;
            busy     <= 1'b0;
            int_stat <= 1'b0;
            cfg      <= '0;
        end else begin
            PREADY <= acc;
            start  <= 1'b0;
            if (done)
                busy <= 1'b0;
            if (acc && PWRITE) begin
                case (PADDR)
                    `DMA_REG_SRC:  if (!busy) cfg.src <= PWDATA;
                    `DMA_REG_DST:  if (!busy) cfg.dst <= PWDATA;
                    `DMA_REG_SIZE: if (!busy) cfg.size <= PWDATA[`DMA_SIZE_W-1:0];
                    `DMA_REG_CTRL: begin
                        if (!busy && PWDATA[0]) begin
                            busy  <= 1'b1;
                            start <= 1'b1;
                        end
                    end
                    `DMA_REG_INT:  if (PWDATA[0]) int_stat <= 1'b0;   // write 1 to clear
                    default: ;
                endcase
            end
            if (done)
                int_stat <= 1'b1;   // a new completion beats a clear
        end
    end

    always_ff @(posedge CLK) begin
        if (acc && !PWRITE)
            PRDATA <= rd_val;
    end

endmodule

//--- design/dma_ctrl.sv
`timescale 1ns/100ps

module dma_ctrl (
    input  logic                     CLK,
    input  logic                     RSTN,
    input  logic                     start,
    input  apb_dma_pkg::dma_cfg_t    cfg,
    output apb_dma_pkg::mem_req_t    rd_req,
    output apb_dma_pkg::rd_beat_t    rd_beat,
    output logic                     flush,
    input  logic                     flush_done,
    output logic                     wr_start,
    input  logic                     wr_done,
    output logic                     done
);

    apb_dma_pkg::ctrl_state_t state;
    apb_dma_pkg::mem_addr_t   rd_addr;
    apb_dma_pkg::wcount_t     rd_left;     // reads still to issue
    apb_dma_pkg::wcount_t     src_words;
    logic [6:0]               src_span;
    logic                     rd_first;

    // source words = ceil((offset + size) / 4)
    assign src_span  = 7'(cfg.size) + 7'(cfg.src[1:0]) + 7'd3;
    assign src_words = apb_dma_pkg::wcount_t'(src_span >> 2);

    always_comb begin
        rd_req       = '0;
        rd_req.en    = (state == apb_dma_pkg::READ);
        rd_req.addr  = rd_addr;
    end

    assign done = (state == apb_dma_pkg::DONE);

    //////////////////////////////////////////////////////////////////////
    // state machine

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            state    <= apb_dma_pkg::IDLE;
            rd_left  <= '0;
            rd_first <= 1'b0;
            rd_beat  <= '0;
            flush    <= 1'b0;
            wr_start <= 1'b0;
        end else begin
            // beat lines up with the data returned a cycle after the request
            rd_beat.valid <= rd_req.en;
            rd_beat.first <= rd_req.en & rd_first;
            rd_beat.last  <= rd_req.en & (rd_left == 1);
            flush         <= rd_beat.valid & rd_beat.last;
            wr_start      <= 1'b0;
            case (state)
                apb_dma_pkg::IDLE: begin
                    if (start) begin
                        if (cfg.size == '0) begin
                            state <= apb_dma_pkg::DONE;   // nothing to move
                        end else begin
                            state    <= apb_dma_pkg::READ;
                            rd_left  <= src_words;
                            rd_first <= 1'b1;
                        end
                    end
                end
                apb_dma_pkg::READ: begin
                    rd_left  <= rd_left - 1'b1;
                    rd_first <= 1'b0;
                    if (rd_left == 1)
                        state <= apb_dma_pkg::FLUSH;
                end
                apb_dma_pkg::FLUSH: begin
                    if (flush_done) begin
                        wr_start <= 1'b1;
                        state    <= apb_dma_pkg::WRITE;
                    end
                end
                apb_dma_pkg::WRITE: if (wr_done) state <= apb_dma_pkg::DONE;
                default: state <= apb_dma_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == apb_dma_pkg::IDLE && start)
            rd_addr <= cfg.src[2 +: $bits(apb_dma_pkg::mem_addr_t)];
        else if (state == apb_dma_pkg::READ)
            rd_addr <= rd_addr + 1'b1;
    end

endmodule

//--- design/dma_aligner.sv
`timescale 1ns/100ps
`include "apb_dma_settings.svh"

module dma_aligner (
    input  logic                  CLK,
    input  logic                  RSTN,
    input  apb_dma_pkg::dma_cfg_t cfg,
    input  apb_dma_pkg::rd_beat_t rd_beat,
    input  apb_dma_pkg::word_t    rd_data,
    input  logic                  flush,
    output logic                  flush_done,
    output apb_dma_pkg::fifo_wr_t fifo_wr
);

    localparam int BUF_W = 2*`DMA_DATA_W - 8;   // seven bytes

    logic [BUF_W-1:0]   buf_q;
    logic [BUF_W-1:0]   base;
    logic [BUF_W-1:0]   merged;
    logic [2:0]         cnt_q;
    logic [2:0]         base_cnt;
    logic [2:0]         take;
    logic [2:0]         total;
    logic [2:0]         lane_hi;
    logic [1:0]         src_end;
    apb_dma_pkg::word_t src_bytes;

    assign src_end = cfg.src[1:0] + cfg.size[1:0];

    always_comb begin
        int i;
        base      = buf_q;
        base_cnt  = cnt_q;
        src_bytes = '0;
        take      = '0;
        lane_hi   = 3'd4;
        if (rd_beat.valid) begin
            if (rd_beat.last && src_end != 2'd0)
                lane_hi = {1'b0, src_end};   // stop at the last source byte
            if (rd_beat.first) begin
                base      = '0;                    // filler below the dest offset
                base_cnt  = {1'b0, cfg.dst[1:0]};
                src_bytes = rd_data >> {cfg.src[1:0], 3'b000};
                take      = lane_hi - {1'b0, cfg.src[1:0]};
            end else begin
                src_bytes = rd_data;
                take      = lane_hi;
            end
            for (i = 0; i < 4; i++) begin
                if (i >= take)
                    src_bytes[8*i +: 8] = 8'h00;
            end
        end
        merged = base | (BUF_W'(src_bytes) << {base_cnt, 3'b000});
        total  = base_cnt + take;
    end

    assign fifo_wr.push = (rd_beat.valid && total >= 3'd4) || (flush && cnt_q != '0);
    assign fifo_wr.data = merged[`DMA_DATA_W-1:0];   // partial word is zero padded

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            cnt_q      <= '0;
            flush_done <= 1'b0;
        end else begin
            flush_done <= flush;
            if (flush)
                cnt_q <= '0;
            else if (fifo_wr.push)
                cnt_q <= total - 3'd4;
            else
                cnt_q <= total;
        end
    end

    always_ff @(posedge CLK) begin
        if (fifo_wr.push && !flush)
            buf_q <= merged >> `DMA_DATA_W;
        else
            buf_q <= merged;
    end

endmodule

//--- design/dma_fifo.sv
`timescale 1ns/100ps
`include "apb_dma_settings.svh"

module dma_fifo (
    input  logic                  CLK,
    input  logic                  RSTN,
    input  apb_dma_pkg::fifo_wr_t fifo_wr,
    input  logic                  pop,
    output apb_dma_pkg::word_t    head,
    output logic                  empty
);

    localparam int PTR_W = $clog2(`DMA_FIFO_DEPTH);

    apb_dma_pkg::word_t mem [`DMA_FIFO_DEPTH];
    logic [PTR_W:0]     wr_ptr;   // extra msb for wrap
    logic [PTR_W:0]     rd_ptr;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (fifo_wr.push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop && !empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (fifo_wr.push)
            mem[wr_ptr[PTR_W-1:0]] <= fifo_wr.data;
    end

    // show-ahead
    assign head  = mem[rd_ptr[PTR_W-1:0]];
    assign empty = (wr_ptr == rd_ptr);

endmodule

//--- design/dma_writer.sv
`timescale 1ns/100ps

module dma_writer (
    input  logic                  CLK,
    input  logic                  RSTN,
    input  logic                  wr_start,
    input  apb_dma_pkg::dma_cfg_t cfg,
    input  apb_dma_pkg::word_t    head,
    input  logic                  empty,
    output logic                  pop,
    output apb_dma_pkg::mem_req_t wr_req,
    output logic                  wr_done
);

    apb_dma_pkg::mem_addr_t wr_addr;
    apb_dma_pkg::wcount_t   wr_left;
    apb_dma_pkg::wcount_t   dst_words;
    apb_dma_pkg::byte_en_t  first_be;
    apb_dma_pkg::byte_en_t  last_be;
    apb_dma_pkg::byte_en_t  be;
    logic [6:0]             dst_span;
    logic [1:0]             dst_end;
    logic                   first_q;
    logic                   fire;

    assign dst_span  = 7'(cfg.size) + 7'(cfg.dst[1:0]) + 7'd3;
    assign dst_words = apb_dma_pkg::wcount_t'(dst_span >> 2);
    assign dst_end   = cfg.dst[1:0] + cfg.size[1:0];

    assign first_be = 4'b1111 << cfg.dst[1:0];
    assign last_be  = (dst_end == 2'd0) ? 4'b1111 : ~(4'b1111 << dst_end);
    // single word transfer gets both masks
    assign be = (first_q ? first_be : 4'b1111) & ((wr_left == 1) ? last_be : 4'b1111);

    assign fire = (wr_left != '0) && !empty;
    assign pop  = fire;

    always_comb begin
        wr_req.en    = fire;
        wr_req.we    = fire ? be : '0;
        wr_req.addr  = wr_addr;
        wr_req.wdata = head;
    end

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            wr_left <= '0;
            first_q <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            wr_done <= fire && (wr_left == 1);
            if (wr_start) begin
                wr_left <= dst_words;
                first_q <= 1'b1;
            end else if (fire) begin
                wr_left <= wr_left - 1'b1;
                first_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_start)
            wr_addr <= cfg.dst[2 +: $bits(apb_dma_pkg::mem_addr_t)];
        else if (fire)
            wr_addr <= wr_addr + 1'b1;
    end

endmodule

//--- design/dma_mem_port.sv
`timescale 1ns/100ps
`include "apb_dma_settings.svh"

module dma_mem_port (
    input  logic                  CLK,
    input  logic                  RSTN,
    input  apb_dma_pkg::dma_cfg_t cfg,
    input  apb_dma_pkg::mem_req_t rd_req,
    input  apb_dma_pkg::mem_req_t wr_req,
    output apb_dma_pkg::word_t    rd_data,
    output apb_dma_pkg::mem_req_t mem0,
    output apb_dma_pkg::mem_req_t mem1,
    input  apb_dma_pkg::word_t    mem0_rdata,
    input  apb_dma_pkg::word_t    mem1_rdata
);

    logic rd_bank0;
    logic wr_bank0;
    logic rd_sel_q;   // bank of the read in flight

    assign rd_bank0 = cfg.src[`DMA_BANK_BIT];
    assign wr_bank0 = cfg.dst[`DMA_BANK_BIT];

    always_comb begin
        mem0 = '0;
        mem1 = '0;
        if (rd_req.en) begin
            if (rd_bank0)
                mem0 = rd_req;
            else
                mem1 = rd_req;
        end else if (wr_req.en) begin
            if (wr_bank0)
                mem0 = wr_req;
            else
                mem1 = wr_req;
        end
    end

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN)
            rd_sel_q <= 1'b0;
        else if (rd_req.en)
            rd_sel_q <= rd_bank0;
    end

    assign rd_data = rd_sel_q ? mem0_rdata : mem1_rdata;

endmodule

//--- design/dma_top.sv
`timescale 1ns/100ps

module dma_top (
    input  logic                  CLK,
    input  logic                  RSTN,
    input  logic                  PSEL,
    input  logic                  PENABLE,
    input  logic                  PWRITE,
    input  apb_dma_pkg::addr_t    PADDR,
    input  apb_dma_pkg::word_t    PWDATA,
    output logic                  PREADY,
    output apb_dma_pkg::word_t    PRDATA,
    output logic                  INTR,
    output apb_dma_pkg::mem_req_t mem0,
    output apb_dma_pkg::mem_req_t mem1,
    input  apb_dma_pkg::word_t    mem0_rdata,
    input  apb_dma_pkg::word_t    mem1_rdata
);

    logic                  start;
    logic                  done;
    logic                  flush;
    logic                  flush_done;
    logic                  wr_start;
    logic                  wr_done;
    logic                  pop;
    logic                  empty;
    apb_dma_pkg::dma_cfg_t cfg;
    apb_dma_pkg::mem_req_t rd_req;
    apb_dma_pkg::mem_req_t wr_req;
    apb_dma_pkg::rd_beat_t rd_beat;
    apb_dma_pkg::fifo_wr_t fifo_wr;
    apb_dma_pkg::word_t    rd_data;
    apb_dma_pkg::word_t    head;

    dma_apb_regs u_regs (
        .CLK(CLK), .RSTN(RSTN), .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
        .PADDR(PADDR), .PWDATA(PWDATA), .PREADY(PREADY), .PRDATA(PRDATA),
        .INTR(INTR), .done(done), .start(start), .cfg(cfg)
    );

    dma_ctrl u_ctrl (
        .CLK(CLK), .RSTN(RSTN), .start(start), .cfg(cfg), .rd_req(rd_req),
        .rd_beat(rd_beat), .flush(flush), .flush_done(flush_done),
        .wr_start(wr_start), .wr_done(wr_done), .done(done)
    );

    dma_aligner u_aligner (
        .CLK(CLK), .RSTN(RSTN), .cfg(cfg), .rd_beat(rd_beat), .rd_data(rd_data),
        .flush(flush), .flush_done(flush_done), .fifo_wr(fifo_wr)
    );

    dma_fifo u_fifo (
        .CLK(CLK), .RSTN(RSTN), .fifo_wr(fifo_wr), .pop(pop), .head(head), .empty(empty)
    );

    dma_writer u_writer (
        .CLK(CLK), .RSTN(RSTN), .wr_start(wr_start), .cfg(cfg), .head(head),
        .empty(empty), .pop(pop), .wr_req(wr_req), .wr_done(wr_done)
    );

    dma_mem_port u_mem_port (
        .CLK(CLK), .RSTN(RSTN), .cfg(cfg), .rd_req(rd_req), .wr_req(wr_req),
        .rd_data(rd_data), .mem0(mem0), .mem1(mem1),
        .mem0_rdata(mem0_rdata), .mem1_rdata(mem1_rdata)
    );

endmodule

//--- bench/apb_dma_props.sv
`timescale 1ns/100ps

module apb_dma_props (
    input logic                  CLK,
    input logic                  RSTN,
    input logic                  PREADY,
    input logic                  INTR,
    input logic                  done,
    input apb_dma_pkg::mem_req_t mem0,
    input apb_dma_pkg::mem_req_t mem1
);

    // one-cycle ready pulse per access
    pready_pulse: assert property (@(posedge CLK) disable iff (!RSTN) PREADY |=> !PREADY)
        else $error("PREADY high for two cycles");

    one_bank: assert property (@(posedge CLK) disable iff (!RSTN) !(mem0.en && mem1.en))
        else $error("mem0 and mem1 enabled together");

    we_en0: assert property (@(posedge CLK) disable iff (!RSTN) (mem0.we != '0) |-> mem0.en)
        else $error("mem0 write enable without enable");

    we_en1: assert property (@(posedge CLK) disable iff (!RSTN) (mem1.we != '0) |-> mem1.en)
        else $error("mem1 write enable without enable");

    intr_after_done: assert property (@(posedge CLK) disable iff (!RSTN)
                                      $rose(INTR) |-> $past(done))
        else $error("INTR rose without done in the cycle before");

endmodule

bind dma_top apb_dma_props u_props (
    .CLK(CLK),
    .RSTN(RSTN),
    .PREADY(PREADY),
    .INTR(INTR),
    .done(done),
    .mem0(mem0),
    .mem1(mem1)
);

//--- bench/tb_apb_dma.sv
`timescale 1ns/100ps
`include "apb_dma_settings.svh"

module tb_apb_dma;

    localparam int WIN        = 4096;   // bytes modelled and checked per memory
    localparam int XFER_BOUND = 80;     // cycles for one programmed transfer
    localparam int NUM_XFERS  = 28;     // 27 copies plus the register test
    localparam int APB_BOUND  = 8;

    logic                  CLK = 1'b0;
    logic                  RSTN;
    logic                  PSEL;
    logic                  PENABLE;
    logic                  PWRITE;
    apb_dma_pkg::addr_t    PADDR;
    apb_dma_pkg::word_t    PWDATA;
    apb_dma_pkg::word_t    PRDATA;
    logic                  PREADY;
    logic                  INTR;
    apb_dma_pkg::mem_req_t mem0;
    apb_dma_pkg::mem_req_t mem1;
    apb_dma_pkg::word_t    mem0_rdata = '0;
    apb_dma_pkg::word_t    mem1_rdata = '0;

    logic [7:0]             mem0_b [0:262143];
    logic [7:0]             mem1_b [0:262143];
    logic [7:0]             exp0 [0:WIN-1];   // reference copies
    logic [7:0]             exp1 [0:WIN-1];
    apb_dma_pkg::mem_addr_t last0 = '0;
    apb_dma_pkg::mem_addr_t last1 = '0;
    int                     errors = 0;
    int                     tests = 0;
    int                     seed = 89886;

    always #10 CLK = ~CLK;

    dma_top uut (
        .CLK(CLK), .RSTN(RSTN), .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
        .PADDR(PADDR), .PWDATA(PWDATA), .PREADY(PREADY), .PRDATA(PRDATA),
        .INTR(INTR), .mem0(mem0), .mem1(mem1),
        .mem0_rdata(mem0_rdata), .mem1_rdata(mem1_rdata)
    );

    //////////////////////////////////////////////////////////////////////
    // memory models with one-cycle read data

    always @(negedge CLK) begin : mem_model
        int lane;
        mem0_rdata <= {mem0_b[{last0, 2'd3}], mem0_b[{last0, 2'd2}],
                       mem0_b[{last0, 2'd1}], mem0_b[{last0, 2'd0}]};
        mem1_rdata <= {mem1_b[{last1, 2'd3}], mem1_b[{last1, 2'd2}],
                       mem1_b[{last1, 2'd1}], mem1_b[{last1, 2'd0}]};
        if (mem0.en)
            last0 <= mem0.addr;
        if (mem1.en)
            last1 <= mem1.addr;
        for (lane = 0; lane < 4; lane++) begin
            if (mem0.en && mem0.we[lane])
                mem0_b[{mem0.addr, 2'(lane)}] <= mem0.wdata[8*lane +: 8];
            if (mem1.en && mem1.we[lane])
                mem1_b[{mem1.addr, 2'(lane)}] <= mem1.wdata[8*lane +: 8];
        end
    end

    function automatic logic [7:0] fill_byte(logic bank, int a, logic [7:0] salt);
        return 8'(a) ^ 8'(a >> 8) ^ salt ^ (bank ? 8'h3c : 8'hc3);
    endfunction

    task automatic load_memories();
        logic [7:0] salt;
        int         a;
        salt = 8'($random(seed));
        for (a = 0; a < WIN; a++) begin
            mem0_b[a] = fill_byte(1'b1, a, salt);
            mem1_b[a] = fill_byte(1'b0, a, salt);
            exp0[a]   = mem0_b[a];
            exp1[a]   = mem1_b[a];
        end
    endtask

    // whole source snapshotted before any write, as in the DMA
    task automatic ref_copy(apb_dma_pkg::addr_t src, apb_dma_pkg::addr_t dst, int size);
        logic [7:0]         tmp [64];
        apb_dma_pkg::addr_t a;
        int                 i;
        for (i = 0; i < size; i++) begin
            a      = src + i;
            tmp[i] = a[`DMA_BANK_BIT] ? exp0[a[11:0]] : exp1[a[11:0]];
        end
        for (i = 0; i < size; i++) begin
            a = dst + i;
            if (a[`DMA_BANK_BIT])
                exp0[a[11:0]] = tmp[i];
            else
                exp1[a[11:0]] = tmp[i];
        end
    endtask

    task automatic check_word(string what, apb_dma_pkg::word_t exp, apb_dma_pkg::word_t act);
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", what, exp, act);
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s: expected %b, actual %b", what, exp, act);
        end
    endtask

    task automatic compare_mem(string name);
        apb_dma_pkg::word_t e;
        apb_dma_pkg::word_t a;
        int                 w;
        for (w = 0; w < WIN/4; w++) begin
            e = {exp0[4*w+3], exp0[4*w+2], exp0[4*w+1], exp0[4*w]};
            a = {mem0_b[4*w+3], mem0_b[4*w+2], mem0_b[4*w+1], mem0_b[4*w]};
            check_word($sformatf("%s mem0 byte 0x%03h", name, 4*w), e, a);
            e = {exp1[4*w+3], exp1[4*w+2], exp1[4*w+1], exp1[4*w]};
            a = {mem1_b[4*w+3], mem1_b[4*w+2], mem1_b[4*w+1], mem1_b[4*w]};
            check_word($sformatf("%s mem1 byte 0x%03h", name, 4*w), e, a);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // APB master

    task automatic apb_access(apb_dma_pkg::addr_t addr, logic wr, apb_dma_pkg::word_t wdata,
                              output apb_dma_pkg::word_t rdata);
        int n;
        @(negedge CLK);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = wr;
        PADDR   = addr;
        PWDATA  = wdata;
        @(negedge CLK);
        PENABLE = 1'b1;
        n = 0;
        do begin
            @(negedge CLK);
            n++;
        end while (!PREADY && n < APB_BOUND);
        if (!PREADY) begin
            errors++;
            $display("APB access to 0x%h got no PREADY within %0d cycles", addr, APB_BOUND);
        end
        rdata   = PRDATA;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
    endtask

    task automatic apb_write(apb_dma_pkg::addr_t addr, apb_dma_pkg::word_t data);
        apb_dma_pkg::word_t unused;
        apb_access(addr, 1'b1, data, unused);
    endtask

    task automatic apb_read(apb_dma_pkg::addr_t addr, output apb_dma_pkg::word_t data);
        apb_access(addr, 1'b0, '0, data);
    endtask

    task automatic wait_intr(string name);
        int n;
        n = 0;
        while (!INTR && n < XFER_BOUND) begin
            @(negedge CLK);
            n++;
        end
        if (!INTR) begin
            errors++;
            $display("%s: no interrupt within %0d cycles", name, XFER_BOUND);
        end
    endtask

    task automatic finish_copy(string name);
        wait_intr(name);
        check_bit({name, " INTR set"}, 1'b1, INTR);
        apb_write(`DMA_REG_INT, 32'h1);
        check_bit({name, " INTR cleared"}, 1'b0, INTR);
        compare_mem(name);
    endtask

    task automatic run_copy(string name, apb_dma_pkg::addr_t src, apb_dma_pkg::addr_t dst,
                            int size);
        apb_write(`DMA_REG_SRC, src);
        apb_write(`DMA_REG_DST, dst);
        apb_write(`DMA_REG_SIZE, apb_dma_pkg::word_t'(size));
        ref_copy(src, dst, size);
        apb_write(`DMA_REG_CTRL, 32'h1);
        finish_copy(name);
    endtask

    task automatic report_test(string name, int errs_before);
        tests++;
        if (errors == errs_before)
            $display("%-12s ok", name);
        else
            $display("%-12s failed with %0d errors", name, errors - errs_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests

    task automatic test_registers();
        apb_dma_pkg::word_t v;
        int                 e0;
        e0 = errors;
        apb_write(`DMA_REG_SRC, 32'h1234_5678);
        apb_write(`DMA_REG_DST, 32'h0010_0abc);
        apb_write(`DMA_REG_SIZE, 32'hffff_ffea);   // only 6 bits kept
        apb_read(`DMA_REG_SRC, v);
        check_word("registers SRC", 32'h1234_5678, v);
        apb_read(`DMA_REG_DST, v);
        check_word("registers DST", 32'h0010_0abc, v);
        apb_read(`DMA_REG_SIZE, v);
        check_word("registers SIZE", 32'h0000_002a, v);
        apb_read(`DMA_REG_CTRL, v);
        check_word("registers CTRL idle", 32'h0, v);
        apb_read(32'h0000_0020, v);
        check_word("registers unmapped", 32'h0, v);
        report_test("registers", e0);
    endtask

    task automatic test_aligned();
        int e0;
        e0 = errors;
        load_memories();
        run_copy("aligned", 32'h0000_0100, 32'h0010_0200, 16);   // mem1 to mem0
        report_test("aligned", e0);
    endtask

    task automatic test_unaligned();
        int e0;
        int soff;
        int doff;
        e0 = errors;
        for (soff = 0; soff < 4; soff++) begin
            for (doff = 0; doff < 4; doff++) begin
                load_memories();
                run_copy($sformatf("unaligned %0d/%0d", soff, doff),
                         32'h0010_0040 + soff, 32'h0000_0080 + doff, 13);
            end
        end
        report_test("unaligned", e0);
    endtask

    task automatic test_size_zero();
        int e0;
        e0 = errors;
        load_memories();
        run_copy("size zero", 32'h0010_0011, 32'h0000_0023, 0);
        report_test("size zero", e0);
    endtask

    task automatic test_random();
        apb_dma_pkg::addr_t src;
        apb_dma_pkg::addr_t dst;
        int                 size;
        int                 e0;
        int                 n;
        e0 = errors;
        load_memories();
        for (n = 0; n < 8; n++) begin
            src = apb_dma_pkg::addr_t'({$random(seed)} % (WIN - 64));
            dst = apb_dma_pkg::addr_t'({$random(seed)} % (WIN - 64));
            src[`DMA_BANK_BIT] = 1'($random(seed));
            dst[`DMA_BANK_BIT] = 1'($random(seed));
            size = 1 + {$random(seed)} % 63;
            run_copy($sformatf("random %0d", n), src, dst, size);
        end
        report_test("random", e0);
    endtask

    task automatic test_busy();
        apb_dma_pkg::word_t v;
        int                 e0;
        e0 = errors;
        load_memories();
        apb_write(`DMA_REG_SRC, 32'h0010_0101);
        apb_write(`DMA_REG_DST, 32'h0000_0402);
        apb_write(`DMA_REG_SIZE, 32'd63);
        ref_copy(32'h0010_0101, 32'h0000_0402, 63);
        apb_write(`DMA_REG_CTRL, 32'h1);
        apb_write(`DMA_REG_SRC, 32'h0000_0203);   // lands mid transfer
        apb_read(`DMA_REG_SRC, v);
        check_word("busy SRC", 32'h0010_0101, v);
        apb_read(`DMA_REG_CTRL, v);
        check_word("busy CTRL", 32'h1, v);
        finish_copy("busy");
        report_test("busy", e0);
    endtask

    initial begin
        RSTN    = 1'b0;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = '0;
        PWDATA  = '0;
        repeat (4) @(negedge CLK);
        RSTN = 1'b1;
        test_registers();
        test_aligned();
        test_unaligned();
        test_size_zero();
        test_random();
        test_busy();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // three times the summed transfer bounds
    initial begin
        repeat (3 * NUM_XFERS * XFER_BOUND) @(posedge CLK);
        $display("watchdog expired after %0d cycles, tests did not finish",
                 3 * NUM_XFERS * XFER_BOUND);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- apb_dma.f
+incdir+include
design/apb_dma_pkg.sv
design/dma_apb_regs.sv
design/dma_ctrl.sv
design/dma_aligner.sv
design/dma_fifo.sv
design/dma_writer.sv
design/dma_mem_port.sv
design/dma_top.sv
bench/apb_dma_props.sv
bench/tb_apb_dma.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_apb_dma
FLIST = apb_dma.f
LOG   = sim.log
BIN   = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: compile
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
